// ==== hw/chan_cfg.svh ====
`ifndef CHAN_CFG_SVH
`define CHAN_CFG_SVH

// waveform memory, 2 samples per word
`define CHAN_MEM_AW     8        // address bits, 256 words
`define CHAN_SAMPLE_W   13       // 12 data bits + over-range flag in the lsb

// event header FIFO
`define CHAN_HDR_DEPTH  16       // words, 3 per event

// APB register window
`define CHAN_APB_AW     12       // byte address bits
`define CHAN_MEM_BASE   12'h400  // start of the memory readout window

`endif

// ==== hw/chan_types_pkg.sv ====
`default_nettype none

`include "chan_cfg.svh"

package chan_types_pkg;

  // one ADC sample as it arrives, over-range in bit 0
  typedef logic [`CHAN_SAMPLE_W-1:0] raw_sample_t;

  // sample after sign extension to a half word
  typedef logic signed [15:0] half_sample_t;

  // memory word, packed as two halves and read back raw
  typedef union packed {
    struct packed {
      half_sample_t hi;   // sample b
      half_sample_t lo;   // sample a
    } pair;
    logic [31:0] raw;     // readout view
  } data_word_u;

  typedef logic [`CHAN_MEM_AW-1:0] mem_addr_t;

  // acquisition FSM
  typedef enum logic [1:0] {
    ACQ_IDLE,    // waiting for arm
    ACQ_ARMED,   // circular writes, waiting for trigger
    ACQ_POST,    // post-trigger words
    ACQ_DONE     // header push, then wait for arm low
  } acq_state_e;

endpackage

`default_nettype wire

// ==== hw/chan_regs_pkg.sv ====
`default_nettype none

`include "chan_cfg.svh"

package chan_regs_pkg;

  // APB byte offsets below the memory window
  typedef enum logic [`CHAN_APB_AW-1:0] {
    REG_BUF_SIZE  = 'h00,   // words kept per event, 2..256
    REG_CHAN_NUM  = 'h04,   // channel number for the header
    REG_POST_SIZE = 'h08,   // words after the trigger, 0..255
    REG_TRIG_NUM  = 'h0C,   // event counter, write loads it
    REG_HDR_POP   = 'h10,   // read pops one header word
    REG_STATUS    = 'h14    // fifo empty and FSM state
  } reg_addr_e;

  // status word layout
  localparam int status_empty_bit = 0;
  localparam int status_state_lsb = 4;

  // order of the header words of one event
  typedef enum logic [1:0] {
    HDR_CHAN,   // channel number
    HDR_TRIG,   // event number
    HDR_STOP    // last written memory address
  } hdr_kind_e;

endpackage

`default_nettype wire

// ==== hw/chan_ifs.sv ====
`default_nettype none

`include "chan_cfg.svh"

// acquisition side of the waveform memory and header FIFO
interface acq_wr_if import chan_types_pkg::*; ();
  logic        wea;
  mem_addr_t   addra;
  data_word_u  dina;
  logic        hdr_wr_en;
  logic [31:0] hdr_din;
  logic        hdr_room;   // 3 or more free entries
  modport acq   (output wea, addra, dina, hdr_wr_en, hdr_din, input hdr_room);
  modport store (input wea, addra, dina, hdr_wr_en, hdr_din, output hdr_room);
endinterface

// readout side, driven from the register block
interface rd_if import chan_types_pkg::*; ();
  mem_addr_t   addrb;
  logic        hdr_rd_en;
  data_word_u  doutb;
  logic [31:0] hdr_dout;
  logic        hdr_empty;
  modport regs  (output addrb, hdr_rd_en, input doutb, hdr_dout, hdr_empty);
  modport store (input addrb, hdr_rd_en, output doutb, hdr_dout, hdr_empty);
endinterface

// configuration into the FSM, counter and state back
interface acq_cfg_if import chan_types_pkg::*; ();
  logic [`CHAN_MEM_AW:0] buf_size;
  mem_addr_t             post_size;
  logic [31:0]           chan_num;
  logic [31:0]           trig_num_init;
  logic                  trig_num_we;
  logic [31:0]           trig_num;
  acq_state_e            state;
  modport regs (output buf_size, post_size, chan_num, trig_num_init, trig_num_we,
                input trig_num, state);
  modport acq  (input buf_size, post_size, chan_num, trig_num_init, trig_num_we,
                output trig_num, state);
endinterface

`default_nettype wire

// ==== hw/acq_control.sv ====
`default_nettype none

`include "chan_cfg.svh"

module acq_control import chan_types_pkg::*, chan_regs_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        acq_arm,     // async to clk
  input  logic        acq_trig,    // async to clk
  input  raw_sample_t adc_dat_a,
  input  raw_sample_t adc_dat_b,
  output logic        acq_done,
  acq_wr_if.acq       wr,
  acq_cfg_if.acq      cfg
);

  logic        arm_meta, arm_s;     // arm synchronizer
  logic        trig_meta, trig_s;   // trigger synchronizer
  raw_sample_t smp_a, smp_b;        // input register
  data_word_u  pack;
  acq_state_e  state;
  mem_addr_t   wr_addr;             // circular write pointer
  mem_addr_t   last_addr;           // stop address for the header
  mem_addr_t   post_left;           // post-trigger words still to write
  logic        wrap;
  logic        hdr_act;             // header words still pending
  hdr_kind_e   hdr_kind;            // next header word
  logic [31:0] trig_num;

  function automatic half_sample_t sext(raw_sample_t s);
    return {{($bits(half_sample_t) - `CHAN_SAMPLE_W){s[`CHAN_SAMPLE_W-1]}}, s};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // synchronizers and sample path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      arm_meta  <= 1'b0;
      arm_s     <= 1'b0;
      trig_meta <= 1'b0;
      trig_s    <= 1'b0;
    end else begin
      arm_meta  <= acq_arm;
      arm_s     <= arm_meta;
      trig_meta <= acq_trig;
      trig_s    <= trig_meta;
    end
  end

  always_ff @(posedge clk) begin
    smp_a <= adc_dat_a;
    smp_b <= adc_dat_b;
  end

  // true sign extension, a in the low half
  always_comb begin
    pack.pair.lo = sext(smp_a);
    pack.pair.hi = sext(smp_b);
  end

  assign wr.dina  = pack;    // memory latches it on the next write edge
  assign wr.addra = wr_addr;
  assign wr.wea   = (state == ACQ_ARMED) || (state == ACQ_POST);
  assign wrap     = ({1'b0, wr_addr} == cfg.buf_size - 1'b1);   // last slot of the ring

  //////////////////////////////////////////////////////////////////////
  // acquisition FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ACQ_IDLE;
      wr_addr   <= '0;
      post_left <= '0;
      hdr_act   <= 1'b0;
      hdr_kind  <= HDR_CHAN;
    end else begin
      if (state != ACQ_DONE) begin   // preload the header sequence
        hdr_act  <= 1'b1;
        hdr_kind <= HDR_CHAN;
      end
      case (state)
        ACQ_IDLE: begin
          wr_addr <= '0;
          if (arm_s && wr.hdr_room) state <= ACQ_ARMED;   // room for one full header
        end
        ACQ_ARMED: begin
          wr_addr <= wrap ? '0 : wr_addr + 1'b1;
          if (!arm_s) begin
            state <= ACQ_IDLE;              // abort, no header
          end else if (trig_s) begin
            post_left <= cfg.post_size;
            state     <= (cfg.post_size == '0) ? ACQ_DONE : ACQ_POST;
          end
        end
        ACQ_POST: begin
          wr_addr   <= wrap ? '0 : wr_addr + 1'b1;
          post_left <= post_left - 1'b1;
          if (!arm_s) state <= ACQ_IDLE;
          else if (post_left == mem_addr_t'(1)) state <= ACQ_DONE;
        end
        default: begin   // ACQ_DONE
          if (hdr_act) begin
            case (hdr_kind)
              HDR_CHAN: hdr_kind <= HDR_TRIG;
              HDR_TRIG: hdr_kind <= HDR_STOP;
              default:  hdr_act  <= 1'b0;   // stop word goes out this edge
            endcase
          end else if (!arm_s) begin
            state <= ACQ_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr.wea) last_addr <= wr_addr;
  end

  //////////////////////////////////////////////////////////////////////
  // header words and event counter
  //////////////////////////////////////////////////////////////////////

  assign wr.hdr_wr_en = (state == ACQ_DONE) && hdr_act;

  always_comb begin
    case (hdr_kind)
      HDR_CHAN: wr.hdr_din = cfg.chan_num;
      HDR_TRIG: wr.hdr_din = trig_num;
      default:  wr.hdr_din = 32'(last_addr);
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) trig_num <= '0;
    else if (cfg.trig_num_we) trig_num <= cfg.trig_num_init;            // register load wins
    else if (wr.hdr_wr_en && hdr_kind == HDR_TRIG) trig_num <= trig_num + 1'b1;
  end

  assign cfg.trig_num = trig_num;
  assign cfg.state    = state;
  assign acq_done     = (state == ACQ_DONE);

endmodule

`default_nettype wire

// ==== hw/event_store.sv ====
`default_nettype none

`include "chan_cfg.svh"

module event_store import chan_types_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  acq_wr_if.store wr,
  rd_if.store     rd
);

  localparam int hdr_aw = $clog2(`CHAN_HDR_DEPTH);
  localparam logic [hdr_aw:0] hdr_depth = `CHAN_HDR_DEPTH;

  data_word_u  wave_mem [2**`CHAN_MEM_AW];   // simple dual port
  data_word_u  doutb_q;
  logic [31:0] hdr_mem [`CHAN_HDR_DEPTH];
  logic [hdr_aw-1:0] wp, rp;                 // fifo pointers
  logic [hdr_aw:0]   count;
  logic push, pop;

  //////////////////////////////////////////////////////////////////////
  // waveform memory
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr.wea) wave_mem[wr.addra] <= wr.dina;
    doutb_q <= wave_mem[rd.addrb];   // one edge read latency
  end

  assign rd.doutb = doutb_q;

  //////////////////////////////////////////////////////////////////////
  // header FIFO, first word falls through
  //////////////////////////////////////////////////////////////////////

  assign push = wr.hdr_wr_en && (count != hdr_depth);
  assign pop  = rd.hdr_rd_en && (count != '0);

  always_ff @(posedge clk) begin
    if (push) hdr_mem[wp] <= wr.hdr_din;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wp    <= '0;
      rp    <= '0;
      count <= '0;
    end else begin
      if (push) wp <= wp + 1'b1;
      if (pop)  rp <= rp + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // idle or both at once
      endcase
    end
  end

  assign rd.hdr_dout  = hdr_mem[rp];      // head word
  assign rd.hdr_empty = (count == '0);
  assign wr.hdr_room  = (count <= hdr_depth - 3'd3);

endmodule

`default_nettype wire

// ==== hw/apb_regs.sv ====
`default_nettype none

`include "chan_cfg.svh"

module apb_regs import chan_types_pkg::*, chan_regs_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [`CHAN_APB_AW-1:0] paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  acq_cfg_if.regs                 cfg,
  rd_if.regs                      rd
);

  localparam int win_lsb = `CHAN_MEM_AW + 2;                 // byte bits of the window
  localparam logic [`CHAN_APB_AW-1:0] mem_base = `CHAN_MEM_BASE;
  localparam logic [`CHAN_MEM_AW:0]   buf_max  = 2**`CHAN_MEM_AW;

  logic [`CHAN_MEM_AW:0] buf_size;
  mem_addr_t             post_size;
  logic [31:0]           chan_num;
  logic access;     // access phase
  logic in_mem;     // address falls in the memory window
  logic mem_wait;   // first access cycle of a window read done
  logic err;
  logic xfer;       // accepted transfer, completes this edge
  logic wr_ok;
  logic idle;
  logic size_ok;

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  assign access  = psel && penable;
  assign in_mem  = (paddr[`CHAN_APB_AW-1:win_lsb] == mem_base[`CHAN_APB_AW-1:win_lsb]);
  assign idle    = (cfg.state == ACQ_IDLE);
  assign size_ok = (pwdata >= 32'd2) && (pwdata <= 32'(buf_max));
  assign rd.addrb = paddr[win_lsb-1:2];   // word index, held through the access

  always_comb begin
    prdata = '0;
    err    = 1'b0;
    if (in_mem) begin
      prdata = rd.doutb.raw;
      err    = pwrite;                    // memory is read only
    end else begin
      case (paddr)
        REG_BUF_SIZE: begin
          prdata = 32'(buf_size);
          err    = pwrite && (!idle || !size_ok);
        end
        REG_CHAN_NUM:  prdata = chan_num;
        REG_POST_SIZE: begin
          prdata = 32'(post_size);
          err    = pwrite && !idle;       // no change mid event
        end
        REG_TRIG_NUM:  prdata = cfg.trig_num;
        REG_HDR_POP: begin
          prdata = rd.hdr_dout;
          err    = !pwrite && rd.hdr_empty;
        end
        REG_STATUS: begin
          prdata[status_empty_bit]                  = rd.hdr_empty;
          prdata[status_state_lsb +: $bits(acq_state_e)] = cfg.state;
        end
        default: err = 1'b1;              // unmapped or misaligned
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) mem_wait <= 1'b0;
    else mem_wait <= access && in_mem && !mem_wait;   // one wait state for the RAM
  end

  assign pready  = access && (!in_mem || mem_wait);
  assign pslverr = pready && err;
  assign xfer    = pready && !err;
  assign wr_ok   = xfer && pwrite;

  assign rd.hdr_rd_en      = xfer && !pwrite && (paddr == REG_HDR_POP);   // pop on completion
  assign cfg.trig_num_we   = wr_ok && (paddr == REG_TRIG_NUM);
  assign cfg.trig_num_init = pwdata;

  //////////////////////////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      buf_size  <= buf_max;
      post_size <= mem_addr_t'(64);
      chan_num  <= '0;
    end else if (wr_ok) begin
      case (paddr)
        REG_BUF_SIZE:  buf_size  <= pwdata[`CHAN_MEM_AW:0];   // range already checked
        REG_POST_SIZE: post_size <= pwdata[`CHAN_MEM_AW-1:0];
        REG_CHAN_NUM:  chan_num  <= pwdata;
        default: ;                        // read only, write ignored
      endcase
    end
  end

  assign cfg.buf_size  = buf_size;
  assign cfg.post_size = post_size;
  assign cfg.chan_num  = chan_num;

endmodule

`default_nettype wire

// ==== hw/channel_top.sv ====
`default_nettype none

`include "chan_cfg.svh"

module channel_top import chan_types_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  // APB slave
  input  logic [`CHAN_APB_AW-1:0] paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  // ADC sample pair
  input  raw_sample_t             adc_dat_a,
  input  raw_sample_t             adc_dat_b,
  // acquisition handshake, async inputs
  input  logic                    acq_arm,
  input  logic                    acq_trig,
  output logic                    acq_done
);

  acq_wr_if  wr_bus ();    // FSM to memory and FIFO
  rd_if      rd_bus ();    // registers to memory and FIFO
  acq_cfg_if cfg_bus ();   // registers to FSM

  acq_control u_acq (
    .clk       (clk),
    .arst_n    (arst_n),
    .acq_arm   (acq_arm),
    .acq_trig  (acq_trig),
    .adc_dat_a (adc_dat_a),
    .adc_dat_b (adc_dat_b),
    .acq_done  (acq_done),
    .wr        (wr_bus.acq),
    .cfg       (cfg_bus.acq)
  );

  event_store u_store (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (wr_bus.store),
    .rd     (rd_bus.store)
  );

  apb_regs u_regs (
    .clk     (clk),
    .arst_n  (arst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cfg     (cfg_bus.regs),
    .rd      (rd_bus.regs)
  );

endmodule

`default_nettype wire

// ==== sim/channel_chk.sv ====
`default_nettype none

module channel_chk import chan_types_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  acq_state_e state,
  input  logic       acq_done,
  input  logic       wea,        // memory write strobe
  input  logic       psel,
  input  logic       penable,
  input  logic       pready,
  input  logic       pslverr
);

  timeunit 1ns;
  timeprecision 1ps;

  int err_cnt = 0;   // read back by the testbench at the end

  // done flag mirrors the FSM
  done_in_done: assert property (@(posedge clk) disable iff (!arst_n)
    acq_done |-> state == ACQ_DONE)
    else begin
      $error("acq_done high outside the done state");
      err_cnt++;
    end

  // ring only written while armed or in post
  write_when_active: assert property (@(posedge clk) disable iff (!arst_n)
    wea |-> state inside {ACQ_ARMED, ACQ_POST})
    else begin
      $error("memory write in idle or done");
      err_cnt++;
    end

  // registers answer at once, memory after one wait state
  ready_in_time: assert property (@(posedge clk) disable iff (!arst_n)
    psel && penable |-> ##[0:1] pready)
    else begin
      $error("pready late after penable");
      err_cnt++;
    end

  err_with_ready: assert property (@(posedge clk) disable iff (!arst_n)
    pslverr |-> pready)
    else begin
      $error("pslverr without pready");
      err_cnt++;
    end

endmodule

bind acq_control channel_chk acq_chk (
  .clk(clk), .arst_n(arst_n), .state(state), .acq_done(acq_done), .wea(wr.wea),
  .psel(1'b0), .penable(1'b0), .pready(1'b0), .pslverr(1'b0)   // no APB here
);

bind apb_regs channel_chk apb_chk (
  .clk(clk), .arst_n(arst_n), .state(cfg.state), .acq_done(1'b0), .wea(1'b0),
  .psel(psel), .penable(penable), .pready(pready), .pslverr(pslverr)
);

`default_nettype wire

// ==== sim/channel_tb.sv ====
`default_nettype none

`include "chan_cfg.svh"

module channel_tb import chan_types_pkg::*, chan_regs_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic                    clk;
  logic                    arst_n;
  logic [`CHAN_APB_AW-1:0] paddr;
  logic                    psel, penable, pwrite;
  logic [31:0]             pwdata, prdata;
  logic                    pready, pslverr;
  raw_sample_t             adc_dat_a, adc_dat_b;
  logic                    acq_arm, acq_trig, acq_done;

  int unsigned base;     // pair index driven in cycle 0
  int unsigned cyc;      // rising edges so far
  int unsigned trig_k;   // pair index driven together with the trigger
  logic [31:0] m_trig;   // expected event number

  channel_top uut (.*);

  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // pair k is 2k and 2k+1, wraps at 13 bits
  always @(negedge clk) begin
    adc_dat_a = raw_sample_t'(2 * (base + cyc));
    adc_dat_b = raw_sample_t'(2 * (base + cyc) + 1);
  end

  // bound checker failures
  always @(uut.u_acq.acq_chk.err_cnt or uut.u_regs.apb_chk.err_cnt) begin
    if (uut.u_acq.acq_chk.err_cnt + uut.u_regs.apb_chk.err_cnt != 0) stop_run();
  end

  //////////////////////////////////////////////////////////////////////
  // model and compare
  //////////////////////////////////////////////////////////////////////

  function automatic half_sample_t to_half(int unsigned v);   // v in 0..8191
    int s;
    s = (v >= 4096) ? int'(v) - 8192 : int'(v);                // 13 bit two's complement
    return half_sample_t'(s);
  endfunction

  function automatic data_word_u pair_word(int unsigned k);
    data_word_u w;
    w.pair.lo = to_half((2 * k) % 8192);       // sample a low
    w.pair.hi = to_half((2 * k + 1) % 8192);
    return w;
  endfunction

  task automatic stop_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string what, input data_word_u got, input data_word_u exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h expected %h", $time, what, got.raw, exp.raw);
      stop_run();
    end
  endtask

  task automatic check_hdr(input hdr_kind_e kind, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: header %s got %h expected %h", $time, kind.name(), got, exp);
      stop_run();
    end
  endtask

  task automatic check_reg(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_err(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: pslverr on %s got %b expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // APB master, called on a falling edge, returns on one
  //////////////////////////////////////////////////////////////////////

  task automatic apb_xfer(input logic [`CHAN_APB_AW-1:0] addr, input logic wr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int n;
    int exp_wait;                    // one wait state inside the memory window
    n        = 0;
    exp_wait = ((addr >= `CHAN_MEM_BASE) &&
                (addr < `CHAN_MEM_BASE + 4 * 2**`CHAN_MEM_AW)) ? 1 : 0;
    paddr   = addr;                  // setup phase
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;                  // access phase
    @(posedge clk);
    while (!pready) begin
      n++;
      if (n == 4) begin
        $display("timeout: no pready within 4 cycles of the access phase");
        stop_run();
      end
      @(posedge clk);
    end
    rdata = prdata;                  // values from before this edge
    err   = pslverr;
    check_reg($sformatf("wait states of the access to %h", addr), n, exp_wait);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic reg_write(input logic [`CHAN_APB_AW-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(addr, 1'b1, data, rd, err);
    check_err($sformatf("write of %h to %h", data, addr), err, exp_err);
  endtask

  task automatic reg_read(input logic [`CHAN_APB_AW-1:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(addr, 1'b0, '0, data, err);
    check_err($sformatf("read of %h", addr), err, 1'b0);
  endtask

  task automatic read_expect(input logic [`CHAN_APB_AW-1:0] addr, input logic [31:0] exp,
                             input string what);
    logic [31:0] v;
    reg_read(addr, v);
    check_reg(what, v, exp);
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!acq_done) begin
      @(negedge clk);
      n++;
      if (n == 1000) begin
        $display("timeout: acq_done never rose after the trigger");
        stop_run();
      end
    end
  endtask

  task automatic wait_state(input acq_state_e st);   // polls REG_STATUS
    logic [31:0] s;
    int          n;
    n = 0;
    reg_read(REG_STATUS, s);
    while (s[5:4] != st) begin
      n++;
      if (n == 50) begin
        $display("timeout: acquisition FSM never reached %s", st.name());
        stop_run();
      end
      reg_read(REG_STATUS, s);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // scenarios
  //////////////////////////////////////////////////////////////////////

  task automatic run_event(input int bs, input int ps, input logic [31:0] ch);
    logic [31:0] v, stop;
    logic        err;
    int unsigned last;
    int          j;
    data_word_u  w;
    reg_write(REG_BUF_SIZE, bs, 1'b0);
    reg_write(REG_POST_SIZE, ps, 1'b0);
    reg_write(REG_CHAN_NUM, ch, 1'b0);
    acq_arm = 1'b1;
    repeat (bs + 8) @(negedge clk);          // ring fully written before the trigger
    acq_trig = 1'b1;
    trig_k   = (base + cyc) % 4096;
    wait_done();
    acq_trig = 1'b0;
    reg_read(REG_HDR_POP, v);
    check_hdr(HDR_CHAN, v, ch);
    reg_read(REG_HDR_POP, v);
    check_hdr(HDR_TRIG, v, m_trig);
    m_trig++;
    reg_read(REG_HDR_POP, stop);
    // first write 4 edges after arm, last one 3+ps edges after the trigger
    check_hdr(HDR_STOP, stop, (bs + 7 + ps) % bs);
    apb_xfer(REG_HDR_POP, 1'b0, '0, v, err);
    check_err("pop of the empty FIFO", err, 1'b1);
    acq_arm = 1'b0;
    wait_state(ACQ_IDLE);
    last = trig_k + ps + 1;                  // sync, input reg and FSM latency
    for (j = 0; j < bs; j++) begin           // oldest word first
      reg_read(`CHAN_MEM_BASE + 4 * ((stop + 1 + j) % bs), v);
      w.raw = v;
      check_word($sformatf("word %0d of a %0d word event", j, bs), w,
                 pair_word(last + 4096 - bs + 1 + j));
    end
  endtask

  task automatic illegal_access();
    logic [31:0] v;
    logic        err;
    reg_write(REG_BUF_SIZE, 32, 1'b0);
    reg_write(REG_POST_SIZE, 5, 1'b0);
    acq_arm = 1'b1;
    wait_state(ACQ_ARMED);
    reg_write(REG_BUF_SIZE, 100, 1'b1);      // locked while armed
    reg_write(REG_POST_SIZE, 9, 1'b1);
    read_expect(REG_BUF_SIZE, 32, "buffer size after a write while armed");
    read_expect(REG_POST_SIZE, 5, "post size after a write while armed");
    acq_arm = 1'b0;
    wait_state(ACQ_IDLE);
    reg_write(REG_BUF_SIZE, 0, 1'b1);        // below range
    reg_write(REG_BUF_SIZE, 300, 1'b1);      // above range
    read_expect(REG_BUF_SIZE, 32, "buffer size after out of range writes");
    reg_write(`CHAN_MEM_BASE + 'h10, 32'h1234, 1'b1);
    apb_xfer('h018, 1'b0, '0, v, err);
    check_err("read of unmapped 0x018", err, 1'b1);
    read_expect(REG_STATUS, 32'h1, "status after the aborted session");
  endtask

  task automatic abort_events();
    acq_arm = 1'b1;                          // drop while armed
    wait_state(ACQ_ARMED);
    acq_arm = 1'b0;
    wait_state(ACQ_IDLE);
    reg_write(REG_BUF_SIZE, 16, 1'b0);
    reg_write(REG_POST_SIZE, 200, 1'b0);
    acq_arm = 1'b1;                          // drop in post
    repeat (24) @(negedge clk);
    acq_trig = 1'b1;
    wait_state(ACQ_POST);
    acq_arm  = 1'b0;
    acq_trig = 1'b0;
    wait_state(ACQ_IDLE);
    read_expect(REG_STATUS, 32'h1, "status after aborts, FIFO empty");
    read_expect(REG_TRIG_NUM, m_trig, "event number after aborts");
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    acq_arm   = 1'b0;
    acq_trig  = 1'b0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    cyc       = 0;
    void'($urandom(32'hfb0ffed8));
    base      = $urandom % 4096;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    read_expect(REG_BUF_SIZE, 256, "buffer size after reset");
    read_expect(REG_CHAN_NUM, 0, "channel number after reset");
    read_expect(REG_POST_SIZE, 64, "post size after reset");
    read_expect(REG_TRIG_NUM, 0, "event number after reset");
    read_expect(REG_STATUS, 32'h1, "status after reset");
    check_reg("acq_done after reset", 32'(acq_done), '0);
    m_trig = $urandom;
    reg_write(REG_TRIG_NUM, m_trig, 1'b0);
    read_expect(REG_TRIG_NUM, m_trig, "event number after load");
    illegal_access();
    repeat (6) run_event(2 + $urandom % 255, $urandom % 256, $urandom);
    abort_events();
    run_event(2 + $urandom % 255, $urandom % 256, $urandom);
    if (uut.u_acq.acq_chk.err_cnt + uut.u_regs.apb_chk.err_cnt == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hw
hw/chan_types_pkg.sv
hw/chan_regs_pkg.sv
hw/chan_ifs.sv
hw/acq_control.sv
hw/event_store.sv
hw/apb_regs.sv
hw/channel_top.sv
sim/channel_chk.sv
sim/channel_tb.sv
